// File: source/fsab_pkg.sv
package fsab_pkg;

	localparam int fsab_addr_w = 8; // Word address
	localparam int fsab_data_w = 64;
	localparam int fsab_mask_w = 8; // One enable per data byte
	localparam int fsab_did_w = 2; // Requester id
	localparam int fsab_subdid_w = 4; // Tag within one requester

	localparam int fsab_devices = 3; // Preload, ic, dc
	localparam int fsab_credits = 4; // Per requester queue depth
	localparam int mem_credits = 4; // Memory request queue depth
	localparam int mem_words = 256;

	localparam int rst_seq_len = 16; // Core reset stretch in cycles
	localparam int preload_words = 16; // Words 0 to 15 get the pattern
	localparam logic [fsab_data_w-1:0] preload_pattern = 64'hA5C3_0F96_5AC3_F069;
	localparam int led_hold_cycles = 64; // Recent-read flag on time

	localparam logic [fsab_did_w-1:0] did_preload = 2'd0;
	localparam logic [fsab_did_w-1:0] did_ic = 2'd1;
	localparam logic [fsab_did_w-1:0] did_dc = 2'd2;

	typedef enum logic {
		fsab_read = 1'b0,
		fsab_write = 1'b1
	} fsab_mode_e;

	// Single beat request, 88 bits
	typedef struct packed {
		logic valid;
		fsab_mode_e mode;
		logic [fsab_did_w-1:0] did;
		logic [fsab_subdid_w-1:0] subdid;
		logic [fsab_addr_w-1:0] addr;
		logic [fsab_data_w-1:0] data; // Ignored on reads
		logic [fsab_mask_w-1:0] mask; // Ignored on reads
	} fsab_req_t;

	// Read data back to requester, 71 bits
	typedef struct packed {
		logic valid;
		logic [fsab_did_w-1:0] did;
		logic [fsab_subdid_w-1:0] subdid;
		logic [fsab_data_w-1:0] data;
	} fsab_resp_t;

	typedef struct packed {
		logic read_seen; // Sticky
		logic read_recent; // Hold timed
	} activity_t;

endpackage

// File: source/rst_sequencer.sv
`timescale 1ns/1ps

module rst_sequencer (
	input  logic cclk,
	input  logic cclk_rst_cause_b, // Async cause, active low
	output logic cclk_rst_b // Clean core reset
);

	logic [fsab_pkg::rst_seq_len-1:0] seq; // Ones shift in after release

	// Cleared at once by the cause, released in step with cclk
	always_ff @(posedge cclk or negedge cclk_rst_cause_b) begin
		if (!cclk_rst_cause_b) begin
			seq <= '0;
		end else begin
			seq <= {seq[fsab_pkg::rst_seq_len-2:0], 1'b1};
		end
	end

	assign cclk_rst_b = seq[fsab_pkg::rst_seq_len-1]; // Last stage

	// Rising edge needs the cause to have been high for the whole stretch
	assert property (@(posedge cclk)
		$rose(cclk_rst_b) |->
			cclk_rst_cause_b && $past(cclk_rst_cause_b, fsab_pkg::rst_seq_len - 1))
		else $error("core reset released while the reset cause was asserted");

endmodule

// File: source/fsab_credit_fifo.sv
`timescale 1ns/1ps

module fsab_credit_fifo (
	input  logic                cclk,
	input  logic                cclk_rst_b,
	input  fsab_pkg::fsab_req_t push, // Enqueued when valid
	input  logic                pop,
	output fsab_pkg::fsab_req_t head, // Oldest entry
	output logic                empty,
	output logic                credit // One pulse per pop
);

	typedef logic [$clog2(fsab_pkg::fsab_credits)-1:0] ptr_t;
	typedef logic [$clog2(fsab_pkg::fsab_credits):0] cnt_t;

	fsab_pkg::fsab_req_t slots [fsab_pkg::fsab_credits]; // Payload storage
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count; // Entries held
	logic do_pop;

	assign empty = (count == '0);
	assign do_pop = pop && !empty; // Pop on empty is ignored
	assign credit = do_pop; // Sender may refill this slot
	assign head = slots[rd_ptr];

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push.valid)
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push.valid, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	always_ff @(posedge cclk) begin
		if (push.valid)
			slots[wr_ptr] <= push; // Visible at head next cycle
	end

	// Sender pushed without holding a credit
	assert property (@(posedge cclk) disable iff (!cclk_rst_b)
		push.valid |-> (count != cnt_t'(fsab_pkg::fsab_credits)))
		else $error("request pushed into a full queue, credit violation");

endmodule

// File: source/fsab_arbiter.sv
`timescale 1ns/1ps

module fsab_arbiter (
	input  logic                cclk,
	input  logic                cclk_rst_b,
	input  fsab_pkg::fsab_req_t pre_req,
	input  fsab_pkg::fsab_req_t ic_req,
	input  fsab_pkg::fsab_req_t dc_req,
	output logic                pre_credit,
	output logic                ic_credit,
	output logic                dc_credit,
	output fsab_pkg::fsab_req_t mem_req, // To memory queue
	input  logic                mem_credit // Memory freed a slot
);

	typedef logic [fsab_pkg::fsab_did_w-1:0] did_t;
	typedef logic [$clog2(fsab_pkg::mem_credits):0] mcnt_t;

	fsab_pkg::fsab_req_t push_q [fsab_pkg::fsab_devices]; // Indexed by did
	fsab_pkg::fsab_req_t head_q [fsab_pkg::fsab_devices];
	logic [fsab_pkg::fsab_devices-1:0] empty_q;
	logic [fsab_pkg::fsab_devices-1:0] pop_q; // One hot on grant
	logic [fsab_pkg::fsab_devices-1:0] credit_q;
	did_t last; // Port granted most recently
	did_t pick; // Next port in rotation with a request
	logic found;
	logic grant;
	mcnt_t mem_cnt; // Free slots in memory queue
	fsab_pkg::fsab_req_t fwd_req; // Registered payload
	logic fwd_valid;

	assign push_q[fsab_pkg::did_preload] = pre_req;
	assign push_q[fsab_pkg::did_ic] = ic_req;
	assign push_q[fsab_pkg::did_dc] = dc_req;
	assign pre_credit = credit_q[fsab_pkg::did_preload];
	assign ic_credit = credit_q[fsab_pkg::did_ic];
	assign dc_credit = credit_q[fsab_pkg::did_dc];

	for (genvar g = 0; g < fsab_pkg::fsab_devices; g++) begin : g_port
		fsab_credit_fifo port_fifo_i (
			.cclk(cclk),
			.cclk_rst_b(cclk_rst_b),
			.push(push_q[g]),
			.pop(pop_q[g]),
			.head(head_q[g]),
			.empty(empty_q[g]),
			.credit(credit_q[g])
		);
		assign pop_q[g] = grant && (pick == did_t'(g));
	end

	// Scan from farthest to nearest so the port right after last wins
	always_comb begin
		int idx;
		found = 1'b0;
		pick = last;
		for (int i = fsab_pkg::fsab_devices; i >= 1; i--) begin
			idx = (int'(last) + i) % fsab_pkg::fsab_devices;
			if (!empty_q[idx]) begin
				found = 1'b1;
				pick = did_t'(idx);
			end
		end
	end

	assign grant = found && (mem_cnt != '0); // Held while memory is full

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			last <= fsab_pkg::did_dc; // Preload port first out of reset
			mem_cnt <= mcnt_t'(fsab_pkg::mem_credits);
			fwd_valid <= 1'b0;
		end else begin
			if (grant)
				last <= pick;
			fwd_valid <= grant;
			case ({grant, mem_credit})
				2'b10: mem_cnt <= mem_cnt - 1'b1; // Slot taken
				2'b01: mem_cnt <= mem_cnt + 1'b1; // Slot returned
				default: mem_cnt <= mem_cnt;
			endcase
		end
	end

	always_ff @(posedge cclk) begin
		if (grant)
			fwd_req <= head_q[pick];
	end

	always_comb begin
		mem_req = fwd_req;
		mem_req.valid = fwd_valid; // Valid from reset-cleared flag
	end

	// Memory returned more credits than it was given
	assert property (@(posedge cclk) disable iff (!cclk_rst_b)
		mem_cnt <= mcnt_t'(fsab_pkg::mem_credits))
		else $error("memory credit count above the memory queue depth");

endmodule

// File: source/fsab_memory.sv
`timescale 1ns/1ps

module fsab_memory (
	input  logic                 cclk,
	input  logic                 cclk_rst_b,
	input  fsab_pkg::fsab_req_t  req, // From arbiter
	output logic                 credit, // Pulse per dequeue
	output fsab_pkg::fsab_resp_t resp, // Broadcast read data
	output logic                 rd_accept // Read dequeued this cycle
);

	fsab_pkg::fsab_req_t head;
	logic empty;
	logic deq;
	logic [fsab_pkg::fsab_data_w-1:0] words [fsab_pkg::mem_words]; // Word array
	logic resp_valid;
	logic [fsab_pkg::fsab_did_w-1:0] rd_did;
	logic [fsab_pkg::fsab_subdid_w-1:0] rd_subdid;
	logic [fsab_pkg::fsab_data_w-1:0] rd_data;

	fsab_credit_fifo req_fifo_i (
		.cclk(cclk),
		.cclk_rst_b(cclk_rst_b),
		.push(req),
		.pop(deq),
		.head(head),
		.empty(empty),
		.credit(credit)
	);

	assign deq = !empty; // One request per cycle
	assign rd_accept = deq && (head.mode == fsab_pkg::fsab_read);

	always_ff @(posedge cclk) begin
		if (deq && (head.mode == fsab_pkg::fsab_write)) begin
			for (int b = 0; b < fsab_pkg::fsab_mask_w; b++) begin
				if (head.mask[b])
					words[head.addr][b*8 +: 8] <= head.data[b*8 +: 8]; // Enabled bytes only
			end
		end
		if (rd_accept) begin
			rd_did <= head.did;
			rd_subdid <= head.subdid;
			rd_data <= words[head.addr]; // Sees all earlier writes
		end
	end

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= rd_accept; // One cycle after dequeue
		end
	end

	always_comb begin
		resp.valid = resp_valid;
		resp.did = rd_did;
		resp.subdid = rd_subdid;
		resp.data = rd_data;
	end

endmodule

// File: source/fsab_preload.sv
`timescale 1ns/1ps

module fsab_preload (
	input  logic                cclk,
	input  logic                cclk_rst_b,
	output fsab_pkg::fsab_req_t req, // Pattern writes
	input  logic                credit, // From preload queue
	output logic                core_rst_b // Core requesters released
);

	typedef logic [$clog2(fsab_pkg::preload_words):0] wcnt_t;
	typedef logic [$clog2(fsab_pkg::fsab_credits):0] ccnt_t;
	typedef logic [fsab_pkg::fsab_addr_w-1:0] addr_t;

	wcnt_t sent_cnt; // Writes issued, also next address
	wcnt_t rtn_cnt; // Credits come back
	ccnt_t cred_cnt; // Credits in hand
	logic send;
	addr_t addr;

	assign send = (sent_cnt != wcnt_t'(fsab_pkg::preload_words)) && (cred_cnt != '0);
	assign addr = addr_t'(sent_cnt);

	always_comb begin
		req.valid = send;
		req.mode = fsab_pkg::fsab_write;
		req.did = fsab_pkg::did_preload;
		req.subdid = sent_cnt[fsab_pkg::fsab_subdid_w-1:0]; // Tag unused for writes
		req.addr = addr;
		req.data = {{(fsab_pkg::fsab_data_w - fsab_pkg::fsab_addr_w){1'b0}}, addr}
			^ fsab_pkg::preload_pattern; // Address mixed into pattern
		req.mask = '1; // Full word
	end

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			sent_cnt <= '0;
			rtn_cnt <= '0;
			cred_cnt <= ccnt_t'(fsab_pkg::fsab_credits);
			core_rst_b <= 1'b0;
		end else begin
			if (send)
				sent_cnt <= sent_cnt + 1'b1;
			if (credit)
				rtn_cnt <= rtn_cnt + 1'b1;
			case ({send, credit})
				2'b10: cred_cnt <= cred_cnt - 1'b1;
				2'b01: cred_cnt <= cred_cnt + 1'b1;
				default: cred_cnt <= cred_cnt;
			endcase
			// Last write handed on to memory path
			if (credit && (rtn_cnt == wcnt_t'(fsab_pkg::preload_words - 1)))
				core_rst_b <= 1'b1; // Stays high until reset
		end
	end

endmodule

// File: source/activity_monitor.sv
`timescale 1ns/1ps

module activity_monitor (
	input  logic                cclk,
	input  logic                cclk_rst_b,
	input  logic                rd_accept, // Memory dequeued a read
	output fsab_pkg::activity_t activity
);

	typedef logic [$clog2(fsab_pkg::led_hold_cycles):0] hold_t;

	hold_t hold_cnt; // Cycles left on recent flag
	logic seen;

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			seen <= 1'b0;
			hold_cnt <= '0;
		end else begin
			if (rd_accept) begin
				seen <= 1'b1; // Sticky until reset
				hold_cnt <= hold_t'(fsab_pkg::led_hold_cycles); // Restart hold
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
		end
	end

	// Both flags rise in the response cycle
	assign activity.read_seen = seen;
	assign activity.read_recent = (hold_cnt != '0);

endmodule

// File: source/fsab_system.sv
`timescale 1ns/1ps

module fsab_system (
	input  logic                 cclk,
	input  logic                 cclk_rst_cause_b, // Async reset cause
	input  fsab_pkg::fsab_req_t  ic_req, // Instruction side
	input  fsab_pkg::fsab_req_t  dc_req, // Data side
	output logic                 ic_credit,
	output logic                 dc_credit,
	output fsab_pkg::fsab_resp_t resp, // Shared by ic and dc
	output logic                 core_rst_b, // High once preload is queued
	output fsab_pkg::activity_t  activity
);

	logic cclk_rst_b; // Stretched reset
	fsab_pkg::fsab_req_t pre_req;
	logic pre_credit;
	fsab_pkg::fsab_req_t mem_req; // Arbiter to memory
	logic mem_credit;
	logic rd_accept;

	rst_sequencer rst_seq_i (
		.cclk(cclk),
		.cclk_rst_cause_b(cclk_rst_cause_b),
		.cclk_rst_b(cclk_rst_b)
	);

	fsab_preload preload_i (
		.cclk(cclk),
		.cclk_rst_b(cclk_rst_b),
		.req(pre_req),
		.credit(pre_credit),
		.core_rst_b(core_rst_b)
	);

	fsab_arbiter arbiter_i (
		.cclk(cclk),
		.cclk_rst_b(cclk_rst_b),
		.pre_req(pre_req),
		.ic_req(ic_req),
		.dc_req(dc_req),
		.pre_credit(pre_credit),
		.ic_credit(ic_credit),
		.dc_credit(dc_credit),
		.mem_req(mem_req),
		.mem_credit(mem_credit)
	);

	fsab_memory memory_i (
		.cclk(cclk),
		.cclk_rst_b(cclk_rst_b),
		.req(mem_req),
		.credit(mem_credit),
		.resp(resp),
		.rd_accept(rd_accept)
	);

	activity_monitor activity_i (
		.cclk(cclk),
		.cclk_rst_b(cclk_rst_b),
		.rd_accept(rd_accept),
		.activity(activity)
	);

endmodule

// File: include/fsab_tb_model.svh
`ifndef FSAB_TB_MODEL_SVH
`define FSAB_TB_MODEL_SVH

typedef logic [fsab_pkg::fsab_data_w-1:0] word_t;

typedef struct packed {
	logic [fsab_pkg::fsab_subdid_w-1:0] subdid; // Tag expected back
	word_t data; // Image when the read was sent
	word_t known; // Ones over bytes with a known value
} fsab_exp_t;

word_t image [int]; // Words touched so far
word_t known_bytes [int]; // Byte lanes holding a known value
int credits [fsab_pkg::fsab_devices]; // Per did
int sent [fsab_pkg::fsab_devices];
int returned [fsab_pkg::fsab_devices]; // Credit pulses seen
fsab_exp_t exp_q [fsab_pkg::fsab_devices][$]; // Reads in request order

// Address zero extended into the constant
function automatic word_t pattern(input int addr);
	word_t word;
	word = '0;
	word[fsab_pkg::fsab_addr_w-1:0] = addr[fsab_pkg::fsab_addr_w-1:0];
	return word ^ fsab_pkg::preload_pattern;
endfunction

function automatic void clear_model();
	for (int d = 0; d < fsab_pkg::fsab_devices; d++) begin
		credits[d] = fsab_pkg::fsab_credits;
		sent[d] = 0;
		returned[d] = 0;
		exp_q[d].delete();
	end
	image.delete();
	known_bytes.delete();
	for (int a = 0; a < fsab_pkg::preload_words; a++) begin
		image[a] = pattern(a); // Preload contents
		known_bytes[a] = '1;
	end
endfunction

function automatic void record_request(input int port, input fsab_pkg::fsab_req_t req);
	fsab_exp_t exp;
	word_t word;
	word_t known;
	int addr;
	addr = int'(req.addr);
	credits[port]--;
	sent[port]++;
	word = image.exists(addr) ? image[addr] : '0;
	known = known_bytes.exists(addr) ? known_bytes[addr] : '0; // Never written
	if (req.mode == fsab_pkg::fsab_write) begin
		for (int b = 0; b < fsab_pkg::fsab_mask_w; b++) begin
			if (req.mask[b]) begin
				word[b*8 +: 8] = req.data[b*8 +: 8];
				known[b*8 +: 8] = '1;
			end
		end
		image[addr] = word;
		known_bytes[addr] = known;
	end else begin
		exp.subdid = req.subdid;
		exp.data = word;
		exp.known = known;
		exp_q[port].push_back(exp);
	end
endfunction

function automatic void credit_back(input int port);
	credits[port]++;
	returned[port]++;
endfunction

`endif

// File: tests/fsab_system_tb.sv
`timescale 1ns/1ps

module fsab_system_tb;

	localparam int clk_period = 8; // ns
	localparam int drive_skew = 1; // Inputs change this long after posedge
	localparam int random_per_port = 150; // Mixed requests per core port
	localparam int total_reqs = 2 * (fsab_pkg::preload_words + random_per_port);
	localparam int cycles_per_req = 6; // Generous bound through arbiter and memory
	localparam int drain_cycles = cycles_per_req * 2 * fsab_pkg::fsab_credits;
	localparam int timeout_cycles = 2 + fsab_pkg::rst_seq_len + 6 * fsab_pkg::preload_words
		+ cycles_per_req * total_reqs + fsab_pkg::led_hold_cycles + 50;

	logic                 cclk;
	logic                 cclk_rst_cause_b;
	fsab_pkg::fsab_req_t  ic_req;
	fsab_pkg::fsab_req_t  dc_req;
	logic                 ic_credit;
	logic                 dc_credit;
	fsab_pkg::fsab_resp_t resp;
	logic                 core_rst_b;
	fsab_pkg::activity_t  activity;

	`include "fsab_tb_model.svh" // Memory image and per-port queues
	int errors;
	int resp_count; // Responses seen so far
	bit core_up; // Set once core_rst_b rose

	fsab_system dut_i (
		.cclk(cclk),
		.cclk_rst_cause_b(cclk_rst_cause_b),
		.ic_req(ic_req),
		.dc_req(dc_req),
		.ic_credit(ic_credit),
		.dc_credit(dc_credit),
		.resp(resp),
		.core_rst_b(core_rst_b),
		.activity(activity)
	);

	always #(clk_period / 2) cclk = ~cclk;

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected,
				$time);
		end
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	function automatic fsab_pkg::fsab_req_t idle_req();
		fsab_pkg::fsab_req_t r;
		r = '0; // Valid low
		return r;
	endfunction

	function automatic fsab_pkg::fsab_req_t build_req(input logic [1:0] did, input bit is_write,
		input int addr);
		fsab_pkg::fsab_req_t r;
		logic [31:0] rnd;
		r.valid = 1'b1;
		r.mode = is_write ? fsab_pkg::fsab_write : fsab_pkg::fsab_read;
		r.did = did;
		rnd = $urandom;
		r.subdid = rnd[fsab_pkg::fsab_subdid_w-1:0]; // Random tag
		r.addr = addr[fsab_pkg::fsab_addr_w-1:0];
		r.data = {$urandom, $urandom};
		rnd = $urandom;
		r.mask = rnd[fsab_pkg::fsab_mask_w-1:0]; // Zero mask allowed
		return r;
	endfunction

	// Present one cycle of requests, then step to the next drive point
	task automatic drive_pair(input fsab_pkg::fsab_req_t ic_next,
		input fsab_pkg::fsab_req_t dc_next);
		ic_req = ic_next;
		dc_req = dc_next;
		if (ic_next.valid)
			record_request(fsab_pkg::did_ic, ic_next);
		if (dc_next.valid)
			record_request(fsab_pkg::did_dc, dc_next);
		@(posedge cclk);
		#drive_skew;
	endtask

	function automatic bit drained();
		return (credits[fsab_pkg::did_ic] == fsab_pkg::fsab_credits)
			&& (credits[fsab_pkg::did_dc] == fsab_pkg::fsab_credits)
			&& (exp_q[fsab_pkg::did_ic].size() == 0)
			&& (exp_q[fsab_pkg::did_dc].size() == 0);
	endfunction

	// Outputs settle mid-cycle, so everything is sampled on the falling edge
	always @(negedge cclk) begin : watch_outputs
		fsab_exp_t exp;
		int port;
		if (core_rst_b === 1'b1)
			core_up = 1'b1;
		else if (core_up)
			report_problem("core_rst_b fell again without a reset");
		if (ic_credit === 1'b1) begin
			if (credits[fsab_pkg::did_ic] >= fsab_pkg::fsab_credits)
				report_problem("ic_credit pulsed with no ic request outstanding");
			else
				credit_back(fsab_pkg::did_ic);
		end
		if (dc_credit === 1'b1) begin
			if (credits[fsab_pkg::did_dc] >= fsab_pkg::fsab_credits)
				report_problem("dc_credit pulsed with no dc request outstanding");
			else
				credit_back(fsab_pkg::did_dc);
		end
		if (resp.valid === 1'b1) begin
			resp_count++;
			port = int'(resp.did);
			check_value("activity.read_recent", activity.read_recent, 1'b1); // Flag lit with data
			if ((port != fsab_pkg::did_ic) && (port != fsab_pkg::did_dc)) begin
				report_problem($sformatf("response carries unknown requester id %0d", port));
			end else if (exp_q[port].size() == 0) begin
				report_problem($sformatf("response for requester %0d with no read pending", port));
			end else begin
				exp = exp_q[port].pop_front(); // Oldest read of that port
				check_value("resp.subdid", resp.subdid, exp.subdid);
				if (exp.known != '0)
					check_value("resp.data", resp.data & exp.known, exp.data); // Known bytes only
			end
		end
		check_value("activity.read_seen", activity.read_seen, resp_count > 0); // Sticky
	end

	initial begin : watchdog
		#(timeout_cycles * clk_period);
		$display("Timeout: test did not finish within %0d cycles", timeout_cycles);
		$display("Simulation failed");
		$finish;
	end

	initial begin : run_test
		int ic_idx;
		int dc_idx;
		int ic_left;
		int dc_left;
		int addr;
		int drain_wait;
		bit wr;
		fsab_pkg::fsab_req_t ic_next;
		fsab_pkg::fsab_req_t dc_next;
		clear_model();
		errors = 0;
		resp_count = 0;
		core_up = 1'b0;
		void'($urandom(76));
		cclk = 1'b0;
		cclk_rst_cause_b = 1'b0;
		ic_req = idle_req();
		dc_req = idle_req();
		@(negedge cclk);
		check_value("resp.valid", resp.valid, 1'b0); // Reset state
		check_value("ic_credit", ic_credit, 1'b0);
		check_value("dc_credit", dc_credit, 1'b0);
		check_value("core_rst_b", core_rst_b, 1'b0);
		check_value("activity.read_seen", activity.read_seen, 1'b0);
		check_value("activity.read_recent", activity.read_recent, 1'b0);
		@(posedge cclk);
		#drive_skew;
		cclk_rst_cause_b = 1'b1; // Released after two rising edges
		while (core_rst_b !== 1'b1)
			@(negedge cclk); // Preload runs alone
		@(posedge cclk);
		#drive_skew;
		// Preload words read back before any write
		ic_idx = 0;
		dc_idx = 0;
		while ((ic_idx < fsab_pkg::preload_words) || (dc_idx < fsab_pkg::preload_words)) begin
			ic_next = idle_req();
			dc_next = idle_req();
			if ((ic_idx < fsab_pkg::preload_words) && (credits[fsab_pkg::did_ic] > 0)) begin
				ic_next = build_req(fsab_pkg::did_ic, 1'b0, ic_idx); // Ascending
				ic_idx++;
			end
			if ((dc_idx < fsab_pkg::preload_words) && (credits[fsab_pkg::did_dc] > 0)) begin
				dc_next = build_req(fsab_pkg::did_dc, 1'b0, fsab_pkg::preload_words - 1 - dc_idx);
				dc_idx++;
			end
			drive_pair(ic_next, dc_next);
		end
		// Mixed traffic, ic on even words and dc on odd words
		ic_left = random_per_port;
		dc_left = random_per_port;
		while ((ic_left > 0) || (dc_left > 0)) begin
			ic_next = idle_req();
			dc_next = idle_req();
			if ((ic_left > 0) && (credits[fsab_pkg::did_ic] > 0) && (($urandom % 4) != 0)) begin
				wr = ($urandom % 2) == 1;
				addr = 2 * int'($urandom % 16);
				ic_next = build_req(fsab_pkg::did_ic, wr, addr);
				ic_left--;
			end
			if ((dc_left > 0) && (credits[fsab_pkg::did_dc] > 0) && (($urandom % 4) != 0)) begin
				wr = ($urandom % 2) == 1;
				addr = 2 * int'($urandom % 16) + 1;
				dc_next = build_req(fsab_pkg::did_dc, wr, addr);
				dc_left--;
			end
			drive_pair(ic_next, dc_next);
		end
		drive_pair(idle_req(), idle_req());
		drain_wait = 0;
		while (!drained() && (drain_wait < drain_cycles)) begin
			@(posedge cclk); // All credits and responses back
			drain_wait++;
		end
		repeat (fsab_pkg::led_hold_cycles + 2)
			@(posedge cclk); // Quiet period, stray pulses still caught
		@(negedge cclk);
		check_value("activity.read_recent", activity.read_recent, 1'b0);
		check_value("ic credit pulses", returned[fsab_pkg::did_ic], sent[fsab_pkg::did_ic]);
		check_value("dc credit pulses", returned[fsab_pkg::did_dc], sent[fsab_pkg::did_dc]);
		check_value("ic reads pending", exp_q[fsab_pkg::did_ic].size(), 0);
		check_value("dc reads pending", exp_q[fsab_pkg::did_dc].size(), 0);
		$display("Run complete: %0d errors, %0d requests sent, %0d responses received", errors,
			sent[fsab_pkg::did_ic] + sent[fsab_pkg::did_dc], resp_count);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: fsab_system.f
+incdir+include
source/fsab_pkg.sv
source/rst_sequencer.sv
source/fsab_credit_fifo.sv
source/fsab_arbiter.sv
source/fsab_memory.sv
source/fsab_preload.sv
source/activity_monitor.sv
source/fsab_system.sv
tests/fsab_system_tb.sv

// File: Makefile
TOP := fsab_system_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): fsab_system.f source/*.sv tests/*.sv include/*.svh
	verilator --binary --timing --assert -j 0 -f fsab_system.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only -Wall --timing -f fsab_system.f --top-module fsab_system

clean:
	rm -rf obj_dir
